// ==== hdl/conv_config.svh ====
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

`define CONV_DATA_W     32      // data word
`define CONV_ADDR_W     12      // word address into data memory
`define CONV_MEM_DEPTH  4096    // words
`define CONV_WT_DIM     3       // window side
`define CONV_MAX_FM_DIM 16      // largest feature map side
`define CONV_LEN_W      5       // burst length field
`define CONV_NUM_REGS   6       // control register count

`endif

// ==== hdl/conv_reg_pkg.sv ====
`include "conv_config.svh"

package conv_reg_pkg;

    typedef logic [$clog2(`CONV_NUM_REGS)-1:0] reg_addr_t;

    // register indices
    localparam reg_addr_t REG_CTRL       = 3'd0;
    localparam reg_addr_t REG_STATUS     = 3'd1;
    localparam reg_addr_t REG_FM_DIM     = 3'd2;
    localparam reg_addr_t REG_WT_OFFSET  = 3'd3;
    localparam reg_addr_t REG_IFM_OFFSET = 3'd4;
    localparam reg_addr_t REG_OFM_OFFSET = 3'd5;

    // CTRL bits, write only
    localparam int CTRL_START_BIT    = 0;
    localparam int CTRL_SOFT_RST_BIT = 1;

    // STATUS bits
    localparam int STATUS_IDLE_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

endpackage

// ==== hdl/mem_chan_pkg.sv ====
`include "conv_config.svh"

package mem_chan_pkg;

    typedef logic signed [`CONV_DATA_W-1:0] word_t;      // pixel, weight or sum
    typedef logic        [`CONV_ADDR_W-1:0] mem_addr_t;  // word address
    typedef logic        [`CONV_LEN_W-1:0]  burst_len_t; // words per burst, never 0

endpackage

// ==== hdl/mem_chan_if.sv ====
interface mem_chan_if;
    import mem_chan_pkg::*;

    mem_addr_t  rd_req_addr;
    burst_len_t rd_req_len;
    logic       rd_req_valid;
    logic       rd_req_ready;

    word_t      rd_resp_data;
    logic       rd_resp_valid;
    logic       rd_resp_ready;

    mem_addr_t  wr_req_addr;
    burst_len_t wr_req_len;
    logic       wr_req_valid;
    logic       wr_req_ready;

    word_t      wr_data;
    logic       wr_data_valid;
    logic       wr_data_ready;

    logic       wr_status_valid;
    logic       wr_status_ready;

    modport engine (
        output rd_req_addr, rd_req_len, rd_req_valid,
        input  rd_req_ready,
        input  rd_resp_data, rd_resp_valid,
        output rd_resp_ready,
        output wr_req_addr, wr_req_len, wr_req_valid,
        input  wr_req_ready,
        output wr_data, wr_data_valid,
        input  wr_data_ready,
        input  wr_status_valid,
        output wr_status_ready
    );

    modport mem (
        input  rd_req_addr, rd_req_len, rd_req_valid,
        output rd_req_ready,
        output rd_resp_data, rd_resp_valid,
        input  rd_resp_ready,
        input  wr_req_addr, wr_req_len, wr_req_valid,
        output wr_req_ready,
        input  wr_data, wr_data_valid,
        output wr_data_ready,
        output wr_status_valid,
        input  wr_status_ready
    );

endinterface

// ==== hdl/dual_port_ram.sv ====
`include "conv_config.svh"

module dual_port_ram (
    input  logic                    clk,
    input  logic                    a_en_i,
    input  logic                    a_we_i,
    input  mem_chan_pkg::mem_addr_t a_addr_i,
    input  mem_chan_pkg::word_t     a_wdata_i,
    output mem_chan_pkg::word_t     a_rdata_o,
    input  logic                    b_we_i,
    input  mem_chan_pkg::mem_addr_t b_addr_i,
    input  mem_chan_pkg::word_t     b_wdata_i
);
    import mem_chan_pkg::*;

    word_t mem_q [`CONV_MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (a_en_i) begin
            a_rdata_o <= mem_q[a_addr_i];  // read before write, held while a_en_i low
            if (a_we_i) begin
                mem_q[a_addr_i] <= a_wdata_i;
            end
        end
        // port b comes last so it wins on an address clash
        if (b_we_i) begin
            mem_q[b_addr_i] <= b_wdata_i;
        end
    end

endmodule

// ==== hdl/mem_port_ctrl.sv ====
module mem_port_ctrl (
    input  logic                    clk,
    input  logic                    reset_i,
    mem_chan_if.mem                 chan,
    input  logic                    host_re_i,
    input  logic                    host_we_i,
    input  mem_chan_pkg::mem_addr_t host_addr_i,
    input  mem_chan_pkg::word_t     host_wdata_i,
    output mem_chan_pkg::word_t     host_rdata_o,
    output logic                    ram_a_en_o,
    output logic                    ram_a_we_o,
    output mem_chan_pkg::mem_addr_t ram_a_addr_o,
    output mem_chan_pkg::word_t     ram_a_wdata_o,
    input  mem_chan_pkg::word_t     ram_a_rdata_i,
    output logic                    ram_b_we_o,
    output mem_chan_pkg::mem_addr_t ram_b_addr_o,
    output mem_chan_pkg::word_t     ram_b_wdata_o
);
    import mem_chan_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE, ST_STATUS} burst_st_t;

    burst_st_t  state_q;
    mem_addr_t  rd_addr_q;
    mem_addr_t  wr_addr_q;
    burst_len_t rd_left_q;    // words still to issue
    burst_len_t wr_left_q;    // words still to accept
    logic       rd_vld_q;     // ram output register holds an unread word
    logic       rd_issue;
    logic       rd_pop;

    assign chan.rd_req_ready    = (state_q == ST_IDLE);
    assign chan.wr_req_ready    = (state_q == ST_IDLE) && !chan.rd_req_valid; // reads first
    assign chan.rd_resp_valid   = rd_vld_q;
    assign chan.rd_resp_data    = ram_a_rdata_i;
    assign chan.wr_data_ready   = (state_q == ST_WRITE);
    assign chan.wr_status_valid = (state_q == ST_STATUS);

    assign rd_pop   = rd_vld_q && chan.rd_resp_ready;
    // a new read overwrites the ram output, so only when it is free or leaving
    assign rd_issue = (state_q == ST_READ) && (rd_left_q != '0) && (!rd_vld_q || rd_pop);

    always_comb begin
        ram_a_en_o   = rd_issue;
        ram_a_we_o   = 1'b0;
        ram_a_addr_o = rd_addr_q;
        if (state_q == ST_IDLE) begin    // host owns port a between bursts
            ram_a_en_o   = host_re_i || host_we_i;
            ram_a_we_o   = host_we_i;
            ram_a_addr_o = host_addr_i;
        end
    end

    assign ram_a_wdata_o = host_wdata_i;
    assign host_rdata_o  = ram_a_rdata_i;
    assign ram_b_we_o    = chan.wr_data_valid && chan.wr_data_ready;
    assign ram_b_addr_o  = wr_addr_q;
    assign ram_b_wdata_o = chan.wr_data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q  <= ST_IDLE;
            rd_vld_q <= 1'b0;
        end else begin
            if (rd_issue) begin
                rd_vld_q <= 1'b1;
            end else if (rd_pop) begin
                rd_vld_q <= 1'b0;
            end
            case (state_q)
                ST_IDLE: begin
                    if (chan.rd_req_valid) begin
                        state_q <= ST_READ;
                    end else if (chan.wr_req_valid) begin
                        state_q <= ST_WRITE;
                    end
                end
                ST_READ: begin
                    if (rd_left_q == '0 && (!rd_vld_q || rd_pop)) begin
                        state_q <= ST_IDLE;     // last word handed over
                    end
                end
                ST_WRITE: begin
                    if (ram_b_we_o && wr_left_q == burst_len_t'(1)) begin
                        state_q <= ST_STATUS;
                    end
                end
                ST_STATUS: begin
                    if (chan.wr_status_ready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE) begin       // captured on the accepting edge
            rd_addr_q <= chan.rd_req_addr;
            rd_left_q <= chan.rd_req_len;
            wr_addr_q <= chan.wr_req_addr;
            wr_left_q <= chan.wr_req_len;
        end
        if (rd_issue) begin
            rd_addr_q <= rd_addr_q + 1'b1;
            rd_left_q <= rd_left_q - 1'b1;
        end
        if (ram_b_we_o) begin
            wr_addr_q <= wr_addr_q + 1'b1;
            wr_left_q <= wr_left_q - 1'b1;
        end
    end

endmodule

// ==== hdl/conv_engine.sv ====
`include "conv_config.svh"

module conv_engine (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    soft_rst_i,
    input  logic                    start_i,
    input  mem_chan_pkg::mem_addr_t fm_dim_i,
    input  mem_chan_pkg::mem_addr_t wt_offset_i,
    input  mem_chan_pkg::mem_addr_t ifm_offset_i,
    input  mem_chan_pkg::mem_addr_t ofm_offset_i,
    output logic                    idle_o,
    output logic                    done_o,
    mem_chan_if.engine              chan
);
    import mem_chan_pkg::*;

    localparam int WT_DIM = `CONV_WT_DIM;
    localparam int NTAPS  = WT_DIM * WT_DIM;
    localparam int HALF   = WT_DIM / 2;

    typedef logic [$clog2(WT_DIM)-1:0] win_t;
    typedef logic [$clog2(NTAPS)-1:0]  tap_t;
    typedef logic [`CONV_ADDR_W:0]     ext_t;    // spare bit for the padding compare

    typedef enum logic [2:0] {
        ST_IDLE, ST_WT_REQ, ST_WT_RD, ST_TAP, ST_TAP_RD, ST_WR_REQ, ST_WR_DATA, ST_WR_STAT
    } eng_st_t;

    eng_st_t   state_q;
    mem_addr_t row_q;
    mem_addr_t col_q;
    win_t      wr_q;         // window row
    win_t      wc_q;         // window column
    tap_t      wt_cnt_q;
    word_t     wt_buf [NTAPS];
    word_t     acc_q;
    ext_t      sum_r;
    ext_t      sum_c;
    mem_addr_t tap_r;
    mem_addr_t tap_c;
    tap_t      tap_idx;
    logic      tap_in;
    logic      tap_step;
    logic      last_tap;
    logic      last_col;
    logic      last_row;

    always_comb begin
        sum_r   = ext_t'(row_q) + ext_t'(wr_q);
        sum_c   = ext_t'(col_q) + ext_t'(wc_q);
        tap_r   = mem_addr_t'(sum_r - ext_t'(HALF));
        tap_c   = mem_addr_t'(sum_c - ext_t'(HALF));
        tap_in  = (sum_r >= ext_t'(HALF)) && (sum_r < ext_t'(fm_dim_i) + ext_t'(HALF)) &&
                  (sum_c >= ext_t'(HALF)) && (sum_c < ext_t'(fm_dim_i) + ext_t'(HALF));
        tap_idx = tap_t'(wr_q * WT_DIM + wc_q);  // row-major, same as the weight burst
    end

    assign last_tap = (wr_q == win_t'(WT_DIM - 1)) && (wc_q == win_t'(WT_DIM - 1));
    assign last_col = (col_q == fm_dim_i - 1'b1);
    assign last_row = (row_q == fm_dim_i - 1'b1);
    // padding taps are skipped in a single cycle
    assign tap_step = (state_q == ST_TAP && !tap_in) ||
                      (state_q == ST_TAP_RD && chan.rd_resp_valid);

    assign idle_o = (state_q == ST_IDLE);

    assign chan.rd_req_valid    = (state_q == ST_WT_REQ) || (state_q == ST_TAP && tap_in);
    assign chan.rd_req_addr     = (state_q == ST_WT_REQ) ? wt_offset_i
                                : ifm_offset_i + tap_r * fm_dim_i + tap_c;
    assign chan.rd_req_len      = (state_q == ST_WT_REQ) ? burst_len_t'(NTAPS) : burst_len_t'(1);
    assign chan.rd_resp_ready   = 1'b1;
    assign chan.wr_req_valid    = (state_q == ST_WR_REQ);
    assign chan.wr_req_addr     = ofm_offset_i + row_q * fm_dim_i + col_q;
    assign chan.wr_req_len      = burst_len_t'(1);
    assign chan.wr_data_valid   = (state_q == ST_WR_DATA);
    assign chan.wr_data         = acc_q;
    assign chan.wr_status_ready = 1'b1;

    always_ff @(posedge clk) begin
        if (reset_i || soft_rst_i) begin
            state_q <= ST_IDLE;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q <= ST_WT_REQ;
                    end
                end
                ST_WT_REQ: begin
                    if (chan.rd_req_ready) begin
                        state_q <= ST_WT_RD;
                    end
                end
                ST_WT_RD: begin
                    if (chan.rd_resp_valid && wt_cnt_q == tap_t'(NTAPS - 1)) begin
                        state_q <= ST_TAP;
                    end
                end
                ST_TAP: begin
                    if (!tap_in && last_tap) begin
                        state_q <= ST_WR_REQ;
                    end else if (tap_in && chan.rd_req_ready) begin
                        state_q <= ST_TAP_RD;
                    end
                end
                ST_TAP_RD: begin
                    if (chan.rd_resp_valid) begin
                        state_q <= last_tap ? ST_WR_REQ : ST_TAP;
                    end
                end
                ST_WR_REQ: begin
                    if (chan.wr_req_ready) begin
                        state_q <= ST_WR_DATA;
                    end
                end
                ST_WR_DATA: begin
                    if (chan.wr_data_ready) begin
                        state_q <= ST_WR_STAT;
                    end
                end
                ST_WR_STAT: begin
                    if (chan.wr_status_valid) begin
                        if (last_col && last_row) begin
                            state_q <= ST_IDLE;
                            done_o  <= 1'b1;    // rises together with idle
                        end else begin
                            state_q <= ST_TAP;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE) begin
            wt_cnt_q <= '0;
            row_q    <= '0;
            col_q    <= '0;
            wr_q     <= '0;
            wc_q     <= '0;
            acc_q    <= '0;
        end
        if (state_q == ST_WT_RD && chan.rd_resp_valid) begin
            wt_buf[wt_cnt_q] <= chan.rd_resp_data;
            wt_cnt_q         <= wt_cnt_q + 1'b1;
        end
        if (state_q == ST_TAP_RD && chan.rd_resp_valid) begin
            acc_q <= acc_q + chan.rd_resp_data * wt_buf[tap_idx];   // wraps at 32 bits
        end
        if (tap_step) begin
            if (wc_q == win_t'(WT_DIM - 1)) begin
                wc_q <= '0;
                wr_q <= wr_q + 1'b1;
            end else begin
                wc_q <= wc_q + 1'b1;
            end
        end
        if (state_q == ST_WR_STAT && chan.wr_status_valid) begin
            acc_q <= '0;
            wr_q  <= '0;
            wc_q  <= '0;
            if (last_col) begin
                col_q <= '0;
                row_q <= row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/conv_regs.sv ====
module conv_regs (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      cfg_we_i,
    input  conv_reg_pkg::reg_addr_t   cfg_addr_i,
    input  mem_chan_pkg::word_t       cfg_wdata_i,
    output mem_chan_pkg::word_t       cfg_rdata_o,
    input  logic                      idle_i,
    input  logic                      done_i,
    output logic                      start_o,
    output logic                      soft_rst_o,
    output mem_chan_pkg::mem_addr_t   fm_dim_o,
    output mem_chan_pkg::mem_addr_t   wt_offset_o,
    output mem_chan_pkg::mem_addr_t   ifm_offset_o,
    output mem_chan_pkg::mem_addr_t   ofm_offset_o
);
    import conv_reg_pkg::*;
    import mem_chan_pkg::*;

    logic  ctrl_wr;
    logic  done_q;      // sticky until the next start
    word_t status_w;
    word_t rdata_d;

    assign ctrl_wr = cfg_we_i && (cfg_addr_i == REG_CTRL);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            start_o      <= 1'b0;
            soft_rst_o   <= 1'b0;
            done_q       <= 1'b0;
            fm_dim_o     <= '0;
            wt_offset_o  <= '0;
            ifm_offset_o <= '0;
            ofm_offset_o <= '0;
        end else begin
            start_o    <= ctrl_wr && cfg_wdata_i[CTRL_START_BIT] && idle_i; // busy start dropped
            soft_rst_o <= ctrl_wr && cfg_wdata_i[CTRL_SOFT_RST_BIT];
            if (done_i) begin
                done_q <= 1'b1;
            end else if (start_o) begin
                done_q <= 1'b0;
            end
            if (cfg_we_i) begin
                case (cfg_addr_i)
                    REG_FM_DIM:     fm_dim_o     <= mem_addr_t'(cfg_wdata_i);
                    REG_WT_OFFSET:  wt_offset_o  <= mem_addr_t'(cfg_wdata_i);
                    REG_IFM_OFFSET: ifm_offset_o <= mem_addr_t'(cfg_wdata_i);
                    REG_OFM_OFFSET: ofm_offset_o <= mem_addr_t'(cfg_wdata_i);
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        status_w                  = '0;
        status_w[STATUS_IDLE_BIT] = idle_i;
        status_w[STATUS_DONE_BIT] = done_q;
        case (cfg_addr_i)
            REG_STATUS:     rdata_d = status_w;
            REG_FM_DIM:     rdata_d = word_t'(fm_dim_o);
            REG_WT_OFFSET:  rdata_d = word_t'(wt_offset_o);
            REG_IFM_OFFSET: rdata_d = word_t'(ifm_offset_o);
            REG_OFM_OFFSET: rdata_d = word_t'(ofm_offset_o);
            default:        rdata_d = '0;    // CTRL reads as zero
        endcase
    end

    always_ff @(posedge clk) begin
        cfg_rdata_o <= rdata_d;
    end

endmodule

// ==== hdl/conv_accel_top.sv ====
module conv_accel_top (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      cfg_we_i,
    input  conv_reg_pkg::reg_addr_t   cfg_addr_i,
    input  mem_chan_pkg::word_t       cfg_wdata_i,
    output mem_chan_pkg::word_t       cfg_rdata_o,
    input  logic                      host_re_i,
    input  logic                      host_we_i,
    input  mem_chan_pkg::mem_addr_t   host_addr_i,
    input  mem_chan_pkg::word_t       host_wdata_i,
    output mem_chan_pkg::word_t       host_rdata_o
);
    import mem_chan_pkg::*;

    logic      conv_start;
    logic      conv_soft_rst;
    logic      conv_idle;
    logic      conv_done;
    mem_addr_t fm_dim;
    mem_addr_t wt_offset;
    mem_addr_t ifm_offset;
    mem_addr_t ofm_offset;
    logic      ram_a_en;
    logic      ram_a_we;
    mem_addr_t ram_a_addr;
    word_t     ram_a_wdata;
    word_t     ram_a_rdata;
    logic      ram_b_we;
    mem_addr_t ram_b_addr;
    word_t     ram_b_wdata;

    mem_chan_if chan ();    // engine <-> memory port bursts

    conv_regs u_regs (
        .clk          (clk),
        .reset_i      (reset_i),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .cfg_rdata_o  (cfg_rdata_o),
        .idle_i       (conv_idle),
        .done_i       (conv_done),
        .start_o      (conv_start),
        .soft_rst_o   (conv_soft_rst),
        .fm_dim_o     (fm_dim),
        .wt_offset_o  (wt_offset),
        .ifm_offset_o (ifm_offset),
        .ofm_offset_o (ofm_offset)
    );

    conv_engine u_engine (
        .clk          (clk),
        .reset_i      (reset_i),
        .soft_rst_i   (conv_soft_rst),
        .start_i      (conv_start),
        .fm_dim_i     (fm_dim),
        .wt_offset_i  (wt_offset),
        .ifm_offset_i (ifm_offset),
        .ofm_offset_i (ofm_offset),
        .idle_o       (conv_idle),
        .done_o       (conv_done),
        .chan         (chan)
    );

    mem_port_ctrl u_port (
        .clk           (clk),
        .reset_i       (reset_i),
        .chan          (chan),
        .host_re_i     (host_re_i),
        .host_we_i     (host_we_i),
        .host_addr_i   (host_addr_i),
        .host_wdata_i  (host_wdata_i),
        .host_rdata_o  (host_rdata_o),
        .ram_a_en_o    (ram_a_en),
        .ram_a_we_o    (ram_a_we),
        .ram_a_addr_o  (ram_a_addr),
        .ram_a_wdata_o (ram_a_wdata),
        .ram_a_rdata_i (ram_a_rdata),
        .ram_b_we_o    (ram_b_we),
        .ram_b_addr_o  (ram_b_addr),
        .ram_b_wdata_o (ram_b_wdata)
    );

    dual_port_ram u_ram (
        .clk       (clk),
        .a_en_i    (ram_a_en),      // burst reads and host access
        .a_we_i    (ram_a_we),
        .a_addr_i  (ram_a_addr),
        .a_wdata_i (ram_a_wdata),
        .a_rdata_o (ram_a_rdata),
        .b_we_i    (ram_b_we),      // burst writes
        .b_addr_i  (ram_b_addr),
        .b_wdata_i (ram_b_wdata)
    );

endmodule

// ==== verification/tb_conv_accel.sv ====
`include "conv_config.svh"

module tb_conv_accel;
    import conv_reg_pkg::*;
    import mem_chan_pkg::*;

    localparam int WT_DIM    = `CONV_WT_DIM;
    localparam int NTAPS     = WT_DIM * WT_DIM;
    localparam int MAX_DIM   = `CONV_MAX_FM_DIM;
    localparam int SR_DIM    = 6;                 // side used around the soft reset
    localparam int RUN_BUDGET = (50 * 8 * 8 + 100) + 8 * (50 * MAX_DIM * MAX_DIM + 100)
                              + 2 * (50 * SR_DIM * SR_DIM + 100);
    localparam int TIMEOUT_CYCLES = 2 * RUN_BUDGET + 2000;

    logic      clk;
    logic      reset;
    logic      cfg_we;
    reg_addr_t cfg_addr;
    word_t     cfg_wdata;
    word_t     cfg_rdata;
    logic      host_re;
    logic      host_we;
    mem_addr_t host_addr;
    word_t     host_wdata;
    word_t     host_rdata;

    word_t model_mem [`CONV_MEM_DEPTH];   // mirror of data memory
    int    rand_addr [32];
    int    errors;
    int    checks;
    int    cycle_cnt;

    conv_accel_top u_dut (
        .clk          (clk),
        .reset_i      (reset),
        .cfg_we_i     (cfg_we),
        .cfg_addr_i   (cfg_addr),
        .cfg_wdata_i  (cfg_wdata),
        .cfg_rdata_o  (cfg_rdata),
        .host_re_i    (host_re),
        .host_we_i    (host_we),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .host_rdata_o (host_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("simulation timed out after %0d cycles", cycle_cnt);
        $display("test failed");
        $finish;
    end

    // all tasks are entered on a falling edge and return on one
    task automatic reg_write(input reg_addr_t addr, input word_t data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output word_t data);
        cfg_addr = addr;
        @(negedge clk);
        data = cfg_rdata;    // registered one edge after the address
    endtask

    task automatic mem_write(input int addr, input word_t data);
        host_we    = 1'b1;
        host_addr  = mem_addr_t'(addr);
        host_wdata = data;
        @(negedge clk);
        host_we         = 1'b0;
        model_mem[addr] = data;
    endtask

    task automatic mem_read(input int addr, output word_t data);
        host_re   = 1'b1;
        host_addr = mem_addr_t'(addr);
        @(negedge clk);
        host_re = 1'b0;
        data    = host_rdata;
    endtask

    function automatic word_t small_value();
        return word_t'(int'($urandom_range(0, 200)) - 100);
    endfunction

    // same-size convolution with zero padding, sums wrap at 32 bits
    function automatic void compute_model(input int n, input int wt, input int ifm, input int ofm);
        int sum;
        int rr;
        int cc;
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                sum = 0;
                for (int i = 0; i < WT_DIM; i++) begin
                    for (int j = 0; j < WT_DIM; j++) begin
                        rr = r + i - WT_DIM / 2;
                        cc = c + j - WT_DIM / 2;
                        if (rr >= 0 && rr < n && cc >= 0 && cc < n) begin
                            sum += model_mem[ifm + rr * n + cc] * model_mem[wt + i * WT_DIM + j];
                        end
                    end
                end
                model_mem[ofm + r * n + c] = word_t'(sum);
            end
        end
    endfunction

    task automatic check_region(input int base, input int count, input string what);
        word_t got;
        for (int i = 0; i < count; i++) begin
            mem_read(base + i, got);
            checks++;
            if (got !== model_mem[base + i]) begin
                errors++;
                $display("FAIL %0t: %s word %0d at address %0d: got %0d, expected %0d",
                         $time, what, i, base + i, got, model_mem[base + i]);
            end
        end
    endtask

    task automatic setup_run(input int n, input int wt, input int ifm, input int ofm);
        reg_write(REG_FM_DIM, word_t'(n));
        reg_write(REG_WT_OFFSET, word_t'(wt));
        reg_write(REG_IFM_OFFSET, word_t'(ifm));
        reg_write(REG_OFM_OFFSET, word_t'(ofm));
        for (int i = 0; i < NTAPS; i++) begin
            mem_write(wt + i, small_value());
        end
        for (int i = 0; i < n * n; i++) begin
            mem_write(ifm + i, small_value());
        end
        compute_model(n, wt, ifm, ofm);
    endtask

    task automatic start_run();
        word_t status;
        reg_write(REG_CTRL, word_t'(1 << CTRL_START_BIT));
        repeat (2) @(negedge clk);    // let start reach the engine
        reg_read(REG_STATUS, status);
        checks++;
        if (status[STATUS_IDLE_BIT] !== 1'b0 || status[STATUS_DONE_BIT] !== 1'b0) begin
            errors++;
            $display("FAIL %0t: STATUS %0h after start, expected busy and done clear",
                     $time, status);
        end
    endtask

    task automatic wait_done(input int n);
        word_t status;
        int    polls;
        bit    finished;
        polls    = 0;
        finished = 1'b0;
        while (!finished && polls < 50 * n * n + 100) begin
            reg_read(REG_STATUS, status);
            polls++;
            finished = (status[STATUS_IDLE_BIT] === 1'b1) && (status[STATUS_DONE_BIT] === 1'b1);
        end
        if (!finished) begin
            errors++;
            $display("run with side %0d timed out waiting for done", n);
        end
    endtask

    task automatic run_conv(input int n, input int wt, input int ifm, input int ofm);
        setup_run(n, wt, ifm, ofm);
        start_run();
        wait_done(n);
        check_region(ofm, n * n, "output");
        check_region(wt, NTAPS, "weight");
        check_region(ifm, n * n, "input");
    endtask

    initial begin
        word_t rd;
        word_t val;
        int    n;
        reset      = 1'b1;
        cfg_we     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        host_re    = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        errors     = 0;
        checks     = 0;
        void'($urandom(25639));
        repeat (4) @(negedge clk);
        reset = 1'b0;

        reg_read(REG_STATUS, rd);    // idle set, done clear
        checks++;
        if (rd !== word_t'(1 << STATUS_IDLE_BIT)) begin
            errors++;
            $display("FAIL %0t: STATUS after reset is %0h", $time, rd);
        end
        for (int k = REG_FM_DIM; k <= REG_OFM_OFFSET; k++) begin
            val = word_t'($urandom_range(0, `CONV_MEM_DEPTH - 1));
            reg_write(reg_addr_t'(k), val);
            reg_read(reg_addr_t'(k), rd);
            checks++;
            if (rd !== val) begin
                errors++;
                $display("FAIL %0t: register %0d read %0h, wrote %0h", $time, k, rd, val);
            end
        end

        for (int i = 0; i < 32; i++) begin
            rand_addr[i] = $urandom_range(0, `CONV_MEM_DEPTH - 1);
            mem_write(rand_addr[i], word_t'($urandom));
        end
        for (int i = 0; i < 32; i++) begin
            mem_read(rand_addr[i], rd);
            checks++;
            if (rd !== model_mem[rand_addr[i]]) begin
                errors++;
                $display("FAIL %0t: host read at %0d got %0h, expected %0h",
                         $time, rand_addr[i], rd, model_mem[rand_addr[i]]);
            end
        end

        run_conv(8, 16, 512, 2048);
        repeat (8) begin    // zones keep weight, input and output apart
            n = $urandom_range(1, MAX_DIM);
            run_conv(n, $urandom_range(0, 255 - NTAPS), 512 + $urandom_range(0, 768),
                     2048 + $urandom_range(0, 1024));
        end

        setup_run(SR_DIM, 32, 1024, 3072);
        start_run();
        reg_write(REG_CTRL, word_t'(1 << CTRL_SOFT_RST_BIT));
        repeat (20) @(negedge clk);    // open weight burst drains
        reg_read(REG_STATUS, rd);
        checks++;
        if (rd !== word_t'(1 << STATUS_IDLE_BIT)) begin
            errors++;
            $display("FAIL %0t: STATUS after soft reset is %0h", $time, rd);
        end
        run_conv(SR_DIM, 32, 1024, 3072);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/conv_reg_pkg.sv
hdl/mem_chan_pkg.sv
hdl/mem_chan_if.sv
hdl/dual_port_ram.sv
hdl/mem_port_ctrl.sv
hdl/conv_engine.sv
hdl/conv_regs.sv
hdl/conv_accel_top.sv
verification/tb_conv_accel.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_conv_accel
FLIST     ?= flist.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir

SRCS    := $(shell grep -v '^+' $(FLIST))
HDRS    := $(wildcard hdl/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) --binary --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
